//--- a23_mem_sub.f
common/a23_bus_pkg.sv
common/a23_core_pkg.sv
common/axi4_if.sv
fetch/a23_fetch.sv
hw/axi4_sram.sv
hw/a23_mem_sub.sv
tb/a23_mem_sub_assertions.sv
tb/tb_a23_mem_sub.sv

//--- common/a23_bus_pkg.sv
/*
 * AXI4 bus widths, response and burst encodings
 * and the memory map of the on-chip SRAM and the error region
 */
package a23_bus_pkg;

	////////////////////////////////////////
	// bus widths
	////////////////////////////////////////
	localparam int AXI_ADDR_W = 32;
	localparam int AXI_DATA_W = 32;
	localparam int AXI_STRB_W = 4;
	localparam int AXI_LEN_W  = 8;
	localparam int AXI_SIZE_W = 3;
	localparam int AXI_PROT_W = 3;

	// single word beats only, 4 bytes
	localparam logic [AXI_SIZE_W-1:0] AXI_SIZE_WORD = 3'd2;

	typedef enum logic [1:0] {
		OKAY   = 2'b00,
		EXOKAY = 2'b01,
		SLVERR = 2'b10,
		DECERR = 2'b11
	} axi_resp_e;

	typedef enum logic [1:0] {
		FIXED = 2'b00,
		INCR  = 2'b01,
		WRAP  = 2'b10
	} axi_burst_e;

	////////////////////////////////////////
	// memory map
	////////////////////////////////////////
	localparam int SRAM_WORDS = 256;
	localparam int SRAM_AW    = $clog2(SRAM_WORDS);
	localparam logic [AXI_ADDR_W-1:0] SRAM_BASE = 32'h0000_0000;
	// anything with bit 31 set is unmapped
	localparam logic [AXI_ADDR_W-1:0] ERR_BASE  = 32'h8000_0000;

endpackage

//--- common/a23_core_pkg.sv
/*
 * core access opcode and the read and write
 * state encodings of the fetch bus unit
 */
package a23_core_pkg;

	// access direction, decoded from the core write enable
	typedef enum logic {
		OP_READ  = 1'b0,
		OP_WRITE = 1'b1
	} core_op_e;

	// read side, AR then R
	typedef enum logic [1:0] {
		RD_IDLE,
		RD_ADDR,
		RD_DATA
	} rd_state_e;

	// write side, AW then W then B
	typedef enum logic [1:0] {
		WR_IDLE,
		WR_ADDR,
		WR_DATA,
		WR_RESP
	} wr_state_e;

endpackage

//--- common/axi4_if.sv
/*
 * single-ID AXI4 channel bundle with master and slave modports
 */
interface axi4_if import a23_bus_pkg::*; ();

	// write address channel
	logic [AXI_ADDR_W-1:0] awaddr;
	logic [AXI_LEN_W-1:0]  awlen;
	logic [AXI_SIZE_W-1:0] awsize;
	axi_burst_e            awburst;
	logic                  awlock;
	logic [AXI_PROT_W-1:0] awprot;
	logic                  awvalid;
	logic                  awready;

	// write data channel
	logic [AXI_DATA_W-1:0] wdata;
	logic [AXI_STRB_W-1:0] wstrb;
	logic                  wlast;
	logic                  wvalid;
	logic                  wready;

	// write response channel
	axi_resp_e             bresp;
	logic                  bvalid;
	logic                  bready;

	// read address channel
	logic [AXI_ADDR_W-1:0] araddr;
	logic [AXI_LEN_W-1:0]  arlen;
	logic [AXI_SIZE_W-1:0] arsize;
	axi_burst_e            arburst;
	logic                  arlock;
	logic [AXI_PROT_W-1:0] arprot;
	logic                  arvalid;
	logic                  arready;

	// read data channel
	logic [AXI_DATA_W-1:0] rdata;
	axi_resp_e             rresp;
	logic                  rlast;
	logic                  rvalid;
	logic                  rready;

	modport master (
		output awaddr, awlen, awsize, awburst, awlock, awprot, awvalid,
		input  awready,
		output wdata, wstrb, wlast, wvalid,
		input  wready,
		input  bresp, bvalid,
		output bready,
		output araddr, arlen, arsize, arburst, arlock, arprot, arvalid,
		input  arready,
		input  rdata, rresp, rlast, rvalid,
		output rready
	);

	modport slave (
		input  awaddr, awlen, awsize, awburst, awlock, awprot, awvalid,
		output awready,
		input  wdata, wstrb, wlast, wvalid,
		output wready,
		output bresp, bvalid,
		input  bready,
		input  araddr, arlen, arsize, arburst, arlock, arprot, arvalid,
		output arready,
		output rdata, rresp, rlast, rvalid,
		input  rready
	);

endinterface

//--- fetch/a23_fetch.sv
/*
 * fetch stage bus unit, one held core access at a time as a
 * single-beat AXI4 transaction, with core stall and abort
 */
module a23_fetch import a23_bus_pkg::*, a23_core_pkg::*; (
	input  logic                  i_clk,
	input  logic                  i_rstn,
	input  logic [AXI_ADDR_W-1:0] i_address,
	input  logic                  i_address_valid,
	input  logic [AXI_DATA_W-1:0] i_write_data,
	input  logic                  i_write_enable,
	input  logic [AXI_STRB_W-1:0] i_byte_enable,
	input  logic                  i_exclusive,
	input  logic                  i_data_access,
	input  logic                  i_privileged,
	input  logic                  i_system_rdy,
	output logic [AXI_DATA_W-1:0] o_read_data,
	output logic                  o_read_data_valid,
	output logic                  o_fetch_stall,
	output logic                  o_dabt,
	axi4_if.master                master
);

	core_op_e              op;
	rd_state_e             rd_state;
	wr_state_e             wr_state;
	logic                  start;
	logic                  rd_done;
	logic                  wr_done;
	logic [AXI_PROT_W-1:0] prot;
	logic [AXI_DATA_W-1:0] rdata_q;
	axi_resp_e             resp_q;

	assign op = i_write_enable ? OP_WRITE : OP_READ;

	// no new transaction in the completion cycle, the core still holds the old request there
	assign start = i_address_valid && i_system_rdy && !rd_done && !wr_done;

	////////////////////////////////////////
	// read side
	////////////////////////////////////////
	always_ff @(posedge i_clk) begin
		if (!i_rstn) begin
			rd_state <= RD_IDLE;
			rd_done  <= 1'b0;
		end else begin
			rd_done <= 1'b0;
			case (rd_state)
				RD_IDLE: begin
					if (start && op == OP_READ) begin
						rd_state <= RD_ADDR;
					end
				end
				// arvalid is up for the whole state
				RD_ADDR: begin
					if (master.arready) begin
						rd_state <= RD_DATA;
					end
				end
				RD_DATA: begin
					if (master.rvalid && master.rlast) begin
						rd_state <= RD_IDLE;
						rd_done  <= 1'b1;
					end
				end
				default: rd_state <= RD_IDLE;
			endcase
		end
	end

	////////////////////////////////////////
	// write side
	////////////////////////////////////////
	always_ff @(posedge i_clk) begin
		if (!i_rstn) begin
			wr_state <= WR_IDLE;
			wr_done  <= 1'b0;
		end else begin
			wr_done <= 1'b0;
			case (wr_state)
				WR_IDLE: begin
					if (start && op == OP_WRITE) begin
						wr_state <= WR_ADDR;
					end
				end
				// address goes out before data
				WR_ADDR: begin
					if (master.awready) begin
						wr_state <= WR_DATA;
					end
				end
				WR_DATA: begin
					if (master.wready) begin
						wr_state <= WR_RESP;
					end
				end
				WR_RESP: begin
					if (master.bvalid) begin
						wr_state <= WR_IDLE;
						wr_done  <= 1'b1;
					end
				end
				default: wr_state <= WR_IDLE;
			endcase
		end
	end

	// response capture, shown to the core one cycle later
	always_ff @(posedge i_clk) begin
		if (rd_state == RD_DATA && master.rvalid) begin
			rdata_q <= master.rdata;
			resp_q  <= master.rresp;
		end else if (wr_state == WR_RESP && master.bvalid) begin
			resp_q  <= master.bresp;
		end
	end

	// prot[0] privileged, prot[2] instruction fetch
	assign prot = {~i_data_access, 1'b0, i_privileged};

	// read channels
	assign master.araddr  = i_address;
	assign master.arlen   = '0;
	assign master.arsize  = AXI_SIZE_WORD;
	assign master.arburst = INCR;
	assign master.arlock  = i_exclusive;
	assign master.arprot  = prot;
	assign master.arvalid = (rd_state == RD_ADDR);
	assign master.rready  = (rd_state == RD_DATA);

	// write channels
	assign master.awaddr  = i_address;
	assign master.awlen   = '0;
	assign master.awsize  = AXI_SIZE_WORD;
	assign master.awburst = INCR;
	assign master.awlock  = i_exclusive;
	assign master.awprot  = prot;
	assign master.awvalid = (wr_state == WR_ADDR);
	assign master.wdata   = i_write_data;
	assign master.wstrb   = i_byte_enable;
	assign master.wlast   = 1'b1;
	assign master.wvalid  = (wr_state == WR_DATA);
	assign master.bready  = (wr_state == WR_RESP);

	////////////////////////////////////////
	// core side
	////////////////////////////////////////
	assign o_read_data       = rdata_q;
	assign o_read_data_valid = rd_done;

	// held from the request until its completion cycle
	assign o_fetch_stall = !i_system_rdy || (i_address_valid && !rd_done && !wr_done);

	// exclusive accesses expect EXOKAY, normal ones OKAY
	assign o_dabt = (rd_done || wr_done) &&
		(i_exclusive ? (resp_q != EXOKAY) : (resp_q != OKAY));

endmodule

//--- hw/a23_mem_sub.sv
/*
 * memory-access subsystem top, fetch bus unit joined
 * to the AXI4 SRAM, core side as plain ports
 */
module a23_mem_sub import a23_bus_pkg::*; (
	input  logic                  i_clk,
	input  logic                  i_rstn,
	input  logic [AXI_ADDR_W-1:0] i_address,
	input  logic                  i_address_valid,
	input  logic                  i_write_enable,
	input  logic [AXI_DATA_W-1:0] i_write_data,
	input  logic [AXI_STRB_W-1:0] i_byte_enable,
	input  logic                  i_exclusive,
	input  logic                  i_data_access,
	input  logic                  i_privileged,
	input  logic                  i_system_rdy,
	output logic [AXI_DATA_W-1:0] o_read_data,
	output logic                  o_read_data_valid,
	output logic                  o_fetch_stall,
	output logic                  o_dabt
);

	// single AXI4 link between bus unit and ram
	axi4_if bus ();

	a23_fetch fetch0 (
		.i_clk             (i_clk),
		.i_rstn            (i_rstn),
		.i_address         (i_address),
		.i_address_valid   (i_address_valid),
		.i_write_data      (i_write_data),
		.i_write_enable    (i_write_enable),
		.i_byte_enable     (i_byte_enable),
		.i_exclusive       (i_exclusive),
		.i_data_access     (i_data_access),
		.i_privileged      (i_privileged),
		.i_system_rdy      (i_system_rdy),
		.o_read_data       (o_read_data),
		.o_read_data_valid (o_read_data_valid),
		.o_fetch_stall     (o_fetch_stall),
		.o_dabt            (o_dabt),
		.master            (bus.master)
	);

	axi4_sram sram0 (
		.i_clk  (i_clk),
		.i_rstn (i_rstn),
		.slave  (bus.slave)
	);

endmodule

//--- hw/axi4_sram.sv
/*
 * single-beat AXI4 slave RAM with byte strobes,
 * one-word exclusive monitor and an SLVERR region
 */
module axi4_sram import a23_bus_pkg::*; (
	input  logic   i_clk,
	input  logic   i_rstn,
	axi4_if.slave  slave
);

	typedef enum logic [2:0] {
		S_IDLE,
		S_RD_MEM,
		S_RD_RESP,
		S_WR_DATA,
		S_WR_MEM,
		S_WR_RESP
	} sram_state_e;

	sram_state_e           state;
	logic [AXI_DATA_W-1:0] mem [SRAM_WORDS];
	logic [AXI_ADDR_W-1:0] addr_q;
	logic [AXI_ADDR_W-1:0] offset;
	logic [SRAM_AW-1:0]    idx;
	logic                  lock_q;
	logic                  shape_err_q;
	logic [AXI_DATA_W-1:0] wdata_q;
	logic [AXI_STRB_W-1:0] wstrb_q;
	logic                  wlast_q;
	logic [AXI_DATA_W-1:0] rdata_q;
	axi_resp_e             resp_q;
	logic                  resv_valid;
	logic [SRAM_AW-1:0]    resv_idx;
	logic                  err;
	logic                  resv_hit;
	logic                  wr_commit;

	// word index inside the sram window
	assign offset = addr_q - SRAM_BASE;
	assign idx    = offset[SRAM_AW+1:2];

	// unmapped or not a plain single word beat
	assign err       = ((addr_q & ERR_BASE) != '0) || shape_err_q;
	assign resv_hit  = resv_valid && (resv_idx == idx);
	// exclusive write only lands on a live reservation
	assign wr_commit = !err && wlast_q && (!lock_q || resv_hit);

	////////////////////////////////////////
	// control
	////////////////////////////////////////
	always_ff @(posedge i_clk) begin
		if (!i_rstn) begin
			state      <= S_IDLE;
			resv_valid <= 1'b0;
		end else begin
			case (state)
				S_IDLE: begin
					if (slave.arvalid) begin
						state <= S_RD_MEM;
					end else if (slave.awvalid) begin
						state <= S_WR_DATA;
					end
				end
				S_RD_MEM: begin
					state <= S_RD_RESP;
					if (!err && lock_q) begin
						resv_valid <= 1'b1;
					end
				end
				S_RD_RESP: begin
					if (slave.rready) begin
						state <= S_IDLE;
					end
				end
				S_WR_DATA: begin
					if (slave.wvalid) begin
						state <= S_WR_MEM;
					end
				end
				S_WR_MEM: begin
					state <= S_WR_RESP;
					// any write that lands on the reserved word ends the reservation
					if (wr_commit && resv_hit) begin
						resv_valid <= 1'b0;
					end
				end
				S_WR_RESP: begin
					if (slave.bready) begin
						state <= S_IDLE;
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	////////////////////////////////////////
	// datapath
	////////////////////////////////////////
	always_ff @(posedge i_clk) begin
		if (state == S_IDLE && slave.arvalid) begin
			addr_q      <= slave.araddr;
			lock_q      <= slave.arlock;
			shape_err_q <= (slave.arlen != '0) || (slave.arsize != AXI_SIZE_WORD) ||
				(slave.arburst == WRAP);
		end else if (state == S_IDLE && slave.awvalid) begin
			addr_q      <= slave.awaddr;
			lock_q      <= slave.awlock;
			shape_err_q <= (slave.awlen != '0) || (slave.awsize != AXI_SIZE_WORD) ||
				(slave.awburst == WRAP);
		end
		if (state == S_WR_DATA && slave.wvalid) begin
			wdata_q <= slave.wdata;
			wstrb_q <= slave.wstrb;
			wlast_q <= slave.wlast;
		end
		if (state == S_RD_MEM) begin
			rdata_q <= err ? '0 : mem[idx];
			resp_q  <= err ? SLVERR : (lock_q ? EXOKAY : OKAY);
			if (!err && lock_q) begin
				resv_idx <= idx;
			end
		end
		if (state == S_WR_MEM) begin
			resp_q <= err ? SLVERR : ((lock_q && wr_commit) ? EXOKAY : OKAY);
		end
	end

	// byte lane writes
	always_ff @(posedge i_clk) begin
		if (state == S_WR_MEM && wr_commit) begin
			for (int b = 0; b < AXI_STRB_W; b++) begin
				if (wstrb_q[b]) begin
					mem[idx][8*b +: 8] <= wdata_q[8*b +: 8];
				end
			end
		end
	end

	// reads take priority when both address channels are valid
	assign slave.arready = (state == S_IDLE);
	assign slave.awready = (state == S_IDLE) && !slave.arvalid;
	assign slave.wready  = (state == S_WR_DATA);
	assign slave.rvalid  = (state == S_RD_RESP);
	assign slave.rdata   = rdata_q;
	assign slave.rresp   = resp_q;
	assign slave.rlast   = 1'b1;
	assign slave.bvalid  = (state == S_WR_RESP);
	assign slave.bresp   = resp_q;

endmodule

//--- tb/a23_mem_sub_assertions.sv
/*
 * bound checker, shadow memory and shadow reservation
 * with concurrent checks on the core side of the subsystem
 */
module a23_mem_sub_assertions import a23_bus_pkg::*, a23_core_pkg::*; (
	input logic                  i_clk,
	input logic                  i_rstn,
	input logic [AXI_ADDR_W-1:0] i_address,
	input logic                  i_address_valid,
	input logic                  i_write_enable,
	input logic [AXI_DATA_W-1:0] i_write_data,
	input logic [AXI_STRB_W-1:0] i_byte_enable,
	input logic                  i_exclusive,
	input logic                  i_data_access,
	input logic                  i_privileged,
	input logic                  i_system_rdy,
	input logic [AXI_DATA_W-1:0] o_read_data,
	input logic                  o_read_data_valid,
	input logic                  o_fetch_stall,
	input logic                  o_dabt,
	input logic                  i_bus_arvalid,
	input logic [AXI_PROT_W-1:0] i_bus_arprot,
	input logic                  i_bus_awvalid,
	input logic [AXI_PROT_W-1:0] i_bus_awprot
);

	timeunit 1ns;
	timeprecision 1ps;

	int                    err_count = 0;
	logic [AXI_DATA_W-1:0] shadow [SRAM_WORDS];
	logic                  resv_valid;
	logic [SRAM_AW-1:0]    resv_idx;
	core_op_e              op;
	logic                  comp;
	logic                  err;
	logic                  hit;
	logic                  commit;
	logic                  exp_dabt;
	logic [SRAM_AW-1:0]    idx;
	logic [AXI_DATA_W-1:0] exp_rdata;
	logic [AXI_DATA_W-1:0] merged;

	assign op   = i_write_enable ? OP_WRITE : OP_READ;
	// completion cycle is where the request is still held without a stall
	assign comp = i_address_valid && !o_fetch_stall;
	assign idx  = i_address[SRAM_AW+1:2];
	assign err  = i_address[31];
	assign hit  = resv_valid && (resv_idx == idx);

	// exclusive write needs the live reservation on this word
	assign commit    = !err && (!i_exclusive || hit);
	assign exp_dabt  = err || (op == OP_WRITE && i_exclusive && !hit);
	assign exp_rdata = shadow[idx];

	// only the enabled bytes replace the old word
	always_comb begin
		merged = shadow[idx];
		for (int b = 0; b < AXI_STRB_W; b++) begin
			if (i_byte_enable[b]) begin
				merged[8*b +: 8] = i_write_data[8*b +: 8];
			end
		end
	end

	////////////////////////////////////////
	// shadow state
	////////////////////////////////////////
	always_ff @(posedge i_clk) begin
		if (!i_rstn) begin
			resv_valid <= 1'b0;
		end else if (comp) begin
			if (op == OP_READ && !err && i_exclusive) begin
				resv_valid <= 1'b1;
				resv_idx   <= idx;
			end
			if (op == OP_WRITE && commit) begin
				shadow[idx] <= merged;
				// any landed write on the reserved word drops it
				if (hit) begin
					resv_valid <= 1'b0;
				end
			end
		end
	end

	////////////////////////////////////////
	// checks
	////////////////////////////////////////
	a_read_data: assert property (@(posedge i_clk) disable iff (!i_rstn)
		comp && op == OP_READ && !err |-> o_read_data === exp_rdata)
		else begin
			err_count++;
			$error("read data differs from the shadow word");
		end

	a_abort: assert property (@(posedge i_clk) disable iff (!i_rstn)
		comp |-> o_dabt == exp_dabt)
		else begin
			err_count++;
			$error("abort flag differs from the expected response check");
		end

	a_valid_in_comp: assert property (@(posedge i_clk) disable iff (!i_rstn)
		o_read_data_valid |-> comp && op == OP_READ)
		else begin
			err_count++;
			$error("read data valid outside a read completion");
		end

	// read done 4 cycles after the request and stalled all along
	a_read_latency: assert property (@(posedge i_clk) disable iff (!i_rstn)
		$rose(i_address_valid) && i_system_rdy && op == OP_READ |->
		o_fetch_stall [*4] ##1 (!o_fetch_stall && o_read_data_valid))
		else begin
			err_count++;
			$error("read stall or latency wrong");
		end

	a_write_latency: assert property (@(posedge i_clk) disable iff (!i_rstn)
		$rose(i_address_valid) && i_system_rdy && op == OP_WRITE |->
		o_fetch_stall [*5] ##1 !o_fetch_stall)
		else begin
			err_count++;
			$error("write stall or latency wrong");
		end

	a_stall_not_ready: assert property (@(posedge i_clk) disable iff (!i_rstn)
		!i_system_rdy |-> o_fetch_stall)
		else begin
			err_count++;
			$error("no stall while the system is not ready");
		end

	// AxPROT bit 0 is the privilege flag and bit 2 marks an instruction fetch
	a_ar_prot: assert property (@(posedge i_clk) disable iff (!i_rstn)
		i_bus_arvalid |-> i_bus_arprot[0] == i_privileged &&
		i_bus_arprot[2] == !i_data_access)
		else begin
			err_count++;
			$error("read address protection bits differ from the access attributes");
		end

	a_aw_prot: assert property (@(posedge i_clk) disable iff (!i_rstn)
		i_bus_awvalid |-> i_bus_awprot[0] == i_privileged &&
		i_bus_awprot[2] == !i_data_access)
		else begin
			err_count++;
			$error("write address protection bits differ from the access attributes");
		end

	a_reset_quiet: assert property (@(posedge i_clk)
		!i_rstn |=> !o_read_data_valid && !o_dabt)
		else begin
			err_count++;
			$error("data valid or abort high right after reset");
		end

endmodule

bind a23_mem_sub a23_mem_sub_assertions chk0 (
	.*,
	.i_bus_arvalid (bus.arvalid),
	.i_bus_arprot  (bus.arprot),
	.i_bus_awvalid (bus.awvalid),
	.i_bus_awprot  (bus.awprot)
);

//--- tb/tb_a23_mem_sub.sv
/*
 * testbench for the memory-access subsystem, drives held core
 * accesses, the bound checker compares against its shadow
 */
module tb_a23_mem_sub import a23_bus_pkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int ACCESS_TIMEOUT = 40;
	localparam int NUM_ADDRS      = 12;

	logic                  i_clk;
	logic                  i_rstn;
	logic [AXI_ADDR_W-1:0] i_address;
	logic                  i_address_valid;
	logic                  i_write_enable;
	logic [AXI_DATA_W-1:0] i_write_data;
	logic [AXI_STRB_W-1:0] i_byte_enable;
	logic                  i_exclusive;
	logic                  i_data_access;
	logic                  i_privileged;
	logic                  i_system_rdy;
	logic [AXI_DATA_W-1:0] o_read_data;
	logic                  o_read_data_valid;
	logic                  o_fetch_stall;
	logic                  o_dabt;

	a23_mem_sub dut0 (.*);

	// 8 ns clock
	initial begin
		i_clk = 1'b0;
		forever #4 i_clk = ~i_clk;
	end

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Test failed");
		$fatal(1, "run stopped");
	endtask

	// present one request on the falling edge
	task automatic drive_request(input logic [AXI_ADDR_W-1:0] addr, input logic we,
		input logic [AXI_DATA_W-1:0] data, input logic [AXI_STRB_W-1:0] be,
		input logic excl);
		@(negedge i_clk);
		i_address       = addr;
		i_write_enable  = we;
		i_write_data    = data;
		i_byte_enable   = be;
		i_exclusive     = excl;
		i_data_access   = 1'($urandom);
		i_privileged    = 1'($urandom);
		i_address_valid = 1'b1;
	endtask

	// stall low marks the completion cycle, the request drops one cycle later
	task automatic wait_completion();
		int n;
		n = 0;
		do begin
			@(negedge i_clk);
			n++;
			if (n > ACCESS_TIMEOUT) begin
				abort_run("timeout: core access never completed");
			end
		end while (o_fetch_stall);
		@(negedge i_clk);
		i_address_valid = 1'b0;
	endtask

	task automatic access(input logic [AXI_ADDR_W-1:0] addr, input logic we,
		input logic [AXI_DATA_W-1:0] data, input logic [AXI_STRB_W-1:0] be,
		input logic excl);
		drive_request(addr, we, data, be, excl);
		wait_completion();
	endtask

	// checker hits show up one half cycle later
	initial begin
		forever begin
			@(negedge i_clk);
			if (dut0.chk0.err_count != 0) begin
				abort_run($sformatf("ERR %0t: bound checker flagged a mismatch", $time));
			end
		end
	end

	initial begin
		logic [AXI_ADDR_W-1:0] addrs [NUM_ADDRS];
		int hold;
		void'($urandom(69));
		i_rstn          = 1'b0;
		i_address       = '0;
		i_address_valid = 1'b0;
		i_write_enable  = 1'b0;
		i_write_data    = '0;
		i_byte_enable   = '0;
		i_exclusive     = 1'b0;
		i_data_access   = 1'b0;
		i_privileged    = 1'b0;
		i_system_rdy    = 1'b1;
		repeat (3) @(posedge i_clk);
		@(negedge i_clk);
		i_rstn = 1'b1;
		repeat (2) @(negedge i_clk);

		//////////////////////////////////////////
		// random writes, partial merges, readback
		//////////////////////////////////////////
		for (int k = 0; k < NUM_ADDRS; k++) begin
			addrs[k] = AXI_ADDR_W'($urandom_range(SRAM_WORDS - 1)) << 2;
			access(addrs[k], 1'b1, $urandom, 4'hf, 1'b0);
			access(addrs[k], 1'b1, $urandom, 4'($urandom), 1'b0);
		end
		for (int k = 0; k < NUM_ADDRS; k++) begin
			access(addrs[k], 1'b0, '0, '0, 1'b0);
		end

		// system not ready, first idle then with a held read
		@(negedge i_clk);
		i_system_rdy = 1'b0;
		repeat (3) @(negedge i_clk);
		drive_request(addrs[0], 1'b0, '0, '0, 1'b0);
		hold = $urandom_range(6, 2);
		repeat (hold) @(negedge i_clk);
		i_system_rdy = 1'b1;
		wait_completion();

		// unmapped region aborts and leaves the aliased word alone
		access(ERR_BASE | addrs[0], 1'b1, $urandom, 4'hf, 1'b0);
		access(ERR_BASE | addrs[0], 1'b0, '0, '0, 1'b0);
		access(addrs[0], 1'b0, '0, '0, 1'b0);

		//////////////////////////////////////////
		// exclusive pairs
		//////////////////////////////////////////
		access(addrs[1], 1'b0, '0, '0, 1'b1);
		access(addrs[1], 1'b1, $urandom, 4'hf, 1'b1);
		access(addrs[1], 1'b0, '0, '0, 1'b0);

		// reservation lost to a normal write in between
		access(addrs[2], 1'b0, '0, '0, 1'b1);
		access(addrs[2], 1'b1, $urandom, 4'($urandom), 1'b0);
		access(addrs[2], 1'b1, $urandom, 4'hf, 1'b1);
		access(addrs[2], 1'b0, '0, '0, 1'b0);

		// no reservation at all
		access(addrs[3], 1'b1, $urandom, 4'hf, 1'b1);
		access(addrs[3], 1'b0, '0, '0, 1'b0);

		repeat (4) @(negedge i_clk);
		if (dut0.chk0.err_count != 0) begin
			abort_run($sformatf("ERR %0t: %0d checker errors at end of run", $time,
				dut0.chk0.err_count));
		end else begin
			$display("Test passed");
			$finish;
		end
	end

endmodule
